// File: hilo_unit.f
+incdir+src
src/hilo_pkg.sv
src/hilo_merge.sv
src/hilo_regs.sv
src/hilo_unit.sv
bench/hilo_unit_sva.sv
bench/hilo_unit_tb.sv

// File: Bender.yml
package:
  name: hilo_unit

sources:
  - include_dirs:
      - src
    files:
      - src/hilo_pkg.sv
      - src/hilo_merge.sv
      - src/hilo_regs.sv
      - src/hilo_unit.sv

  - target: test
    include_dirs:
      - src
    files:
      - bench/hilo_unit_sva.sv
      - bench/hilo_unit_tb.sv

// File: bench/hilo_unit_tb.sv
`include "hilo_consts.svh"

module hilo_unit_tb;
    import hilo_pkg::*;

    localparam int NROWS = 14;
    localparam int NRAND = 200;

    logic            clk;
    logic            reset;
    hilo_slot_pair_t i_slots;
    word_t           o_hi;
    word_t           o_lo;
    word_t           o_hi_next;
    word_t           o_lo_next;
    logic            o_hi_pending;
    logic            o_lo_pending;

    // stimulus table, slot index 0 is the younger slot
    string           row_name  [NROWS];
    hilo_slot_pair_t row_slots [NROWS];
    word_t           row_hi    [NROWS];
    word_t           row_lo    [NROWS];

    integer          seed;
    int              n_checks;
    int              n_errors;
    logic            released;
    hilo_slot_pair_t rnd_slots;
    word_t           model_hi;
    word_t           model_lo;
    word_t           exp_hi;
    word_t           exp_lo;
    logic            exp_phi;
    logic            exp_plo;

    hilo_unit i_hilo_unit (
        .clk          (clk),
        .reset        (reset),
        .i_slots      (i_slots),
        .o_hi         (o_hi),
        .o_lo         (o_lo),
        .o_hi_next    (o_hi_next),
        .o_lo_next    (o_lo_next),
        .o_hi_pending (o_hi_pending),
        .o_lo_pending (o_lo_pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic hilo_slot_t make_slot(input logic hw, input logic lw,
                                             input hilo_op_e op, input word_t src,
                                             input dword_t product);
        hilo_slot_t s;
        s.hi_write = hw;
        s.lo_write = lw;
        s.op       = op;
        s.src      = src;
        s.product  = product;
        return s;
    endfunction

    task automatic set_row(input int idx, input string name, input hilo_slot_t young,
                           input hilo_slot_t old, input word_t hi, input word_t lo);
        row_name[idx]     = name;
        row_slots[idx][0] = young;
        row_slots[idx][1] = old;
        row_hi[idx]       = hi;
        row_lo[idx]       = lo;
    endtask

    // expected values worked out by hand, each row starts from the previous one
    task automatic load_table();
        hilo_slot_t idle;
        idle = '0;
        set_row(0, "mthi", make_slot(1, 0, HILO_MOVE, 32'h1234_5678, 64'h0), idle,
                32'h1234_5678, 32'h0000_0000);
        set_row(1, "mtlo_old_slot", idle, make_slot(0, 1, HILO_MOVE, 32'hcafe_f00d, 64'h0),
                32'h1234_5678, 32'hcafe_f00d);
        set_row(2, "mult_both", make_slot(1, 1, HILO_SET, 32'h0, 64'h0000_0001_ffff_fffe),
                idle, 32'h0000_0001, 32'hffff_fffe);
        set_row(3, "set_lo_only", make_slot(0, 1, HILO_SET, 32'h0, 64'haaaa_aaaa_5555_5555),
                idle, 32'h0000_0001, 32'h5555_5555);
        set_row(4, "set_hi_only", idle, make_slot(1, 0, HILO_SET, 32'h0, 64'h7777_7777_8888_8888),
                32'h7777_7777, 32'h5555_5555);
        // LO overflows into HI
        set_row(5, "madd_carry", make_slot(1, 1, HILO_ADD, 32'h0, 64'h0000_0000_b000_0000),
                idle, 32'h7777_7778, 32'h0555_5555);
        set_row(6, "msub_borrow", make_slot(1, 1, HILO_SUB, 32'h0, 64'h0000_0000_1000_0000),
                idle, 32'h7777_7777, 32'hf555_5555);
        set_row(7, "mthi_both_young_wins", make_slot(1, 0, HILO_MOVE, 32'h2222_2222, 64'h0),
                make_slot(1, 0, HILO_MOVE, 32'h1111_1111, 64'h0), 32'h2222_2222, 32'hf555_5555);
        set_row(8, "set_lo_both", make_slot(0, 1, HILO_SET, 32'h0, 64'h5555_5555_6666_6666),
                make_slot(1, 1, HILO_SET, 32'h0, 64'h3333_3333_4444_4444),
                32'h3333_3333, 32'h6666_6666);
        // accumulates in both slots do not chain
        set_row(9, "madd_pair", make_slot(1, 1, HILO_ADD, 32'h0, 64'h10),
                make_slot(1, 1, HILO_ADD, 32'h0, 64'h1), 32'h3333_3333, 32'h6666_6676);
        set_row(10, "madd_msub_pair", make_slot(1, 1, HILO_SUB, 32'h0, 64'h6),
                make_slot(1, 1, HILO_ADD, 32'h0, 64'h1_0000_0000), 32'h3333_3333, 32'h6666_6670);
        set_row(11, "idle", idle, idle, 32'h3333_3333, 32'h6666_6670);
        set_row(12, "mthi_young_mtlo_old", make_slot(1, 0, HILO_MOVE, 32'h0bad_cafe, 64'h0),
                make_slot(0, 1, HILO_MOVE, 32'hdead_beef, 64'h0), 32'h0bad_cafe, 32'hdead_beef);
        set_row(13, "msub_full_borrow", make_slot(1, 1, HILO_SUB, 32'h0, 64'hdead_beef_ffff_ffff),
                idle, 32'h2d00_0c0e, 32'hdead_bef0);
    endtask

    task automatic verify_word(input string name, input word_t expected, input word_t actual);
        n_checks++;
        assert (actual === expected) else begin
            n_errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic expect_bit(input string name, input logic expected, input logic actual);
        n_checks++;
        assert (actual === expected) else begin
            n_errors++;
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // value one slot would give a half, against the registered pair
    function automatic word_t slot_half(input hilo_slot_t s, input word_t cur_hi,
                                        input word_t cur_lo, input bit upper);
        dword_t cur;
        dword_t val;
        cur = {cur_hi, cur_lo};
        case (s.op)
            HILO_MOVE: val = {s.src, s.src};
            HILO_SET:  val = s.product;
            HILO_ADD:  val = cur + s.product;
            default:   val = cur - s.product;
        endcase
        if (upper) begin
            return val[`HILO_WORD_W +: `HILO_WORD_W];
        end
        return val[0 +: `HILO_WORD_W];
    endfunction

    // reference merge, younger slot 0 first
    task automatic model_next(input hilo_slot_pair_t s, input word_t cur_hi, input word_t cur_lo,
                              output word_t nhi, output word_t nlo,
                              output logic phi, output logic plo);
        nhi = cur_hi;
        nlo = cur_lo;
        phi = s[0].hi_write | s[1].hi_write;
        plo = s[0].lo_write | s[1].lo_write;
        if (s[0].hi_write) begin
            nhi = slot_half(s[0], cur_hi, cur_lo, 1'b1);
        end else if (s[1].hi_write) begin
            nhi = slot_half(s[1], cur_hi, cur_lo, 1'b1);
        end
        if (s[0].lo_write) begin
            nlo = slot_half(s[0], cur_hi, cur_lo, 1'b0);
        end else if (s[1].lo_write) begin
            nlo = slot_half(s[1], cur_hi, cur_lo, 1'b0);
        end
    endtask

    task automatic random_slots(output hilo_slot_pair_t s);
        logic [31:0] r;
        for (int k = 0; k < `HILO_SLOTS; k++) begin
            r             = $random(seed);
            s[k].hi_write = r[0];
            s[k].lo_write = r[1];
            s[k].op       = hilo_op_e'(r[3:2]);
            s[k].src      = $random(seed);
            s[k].product  = {$random(seed), $random(seed)};
        end
    endtask

    task automatic wait_reset_release(output logic ok);
        ok = 1'b0;
        for (int i = 0; i < 20 && !ok; i++) begin
            @(negedge clk);
            if (!reset) begin
                ok = 1'b1;
            end
        end
    endtask

    // one row per two cycles, forwarded values first and registers after the edge
    task automatic apply_table();
        for (int r = 0; r < NROWS; r++) begin
            @(posedge clk);
            i_slots <= row_slots[r];
            @(negedge clk);
            verify_word({row_name[r], "_hi_next"}, row_hi[r], o_hi_next);
            verify_word({row_name[r], "_lo_next"}, row_lo[r], o_lo_next);
            expect_bit({row_name[r], "_hi_pending"},
                       row_slots[r][0].hi_write | row_slots[r][1].hi_write, o_hi_pending);
            expect_bit({row_name[r], "_lo_pending"},
                       row_slots[r][0].lo_write | row_slots[r][1].lo_write, o_lo_pending);
            @(posedge clk);
            i_slots <= '0;
            @(negedge clk);
            verify_word({row_name[r], "_hi"}, row_hi[r], o_hi);
            verify_word({row_name[r], "_lo"}, row_lo[r], o_lo);
        end
    endtask

    // back-to-back random pairs against the reference model
    task automatic check_random();
        model_hi = row_hi[NROWS-1];
        model_lo = row_lo[NROWS-1];
        for (int n = 0; n < NRAND; n++) begin
            random_slots(rnd_slots);
            @(posedge clk);
            i_slots <= rnd_slots;
            @(negedge clk);
            model_next(rnd_slots, model_hi, model_lo, exp_hi, exp_lo, exp_phi, exp_plo);
            verify_word($sformatf("random_%0d_hi", n), model_hi, o_hi);
            verify_word($sformatf("random_%0d_lo", n), model_lo, o_lo);
            verify_word($sformatf("random_%0d_hi_next", n), exp_hi, o_hi_next);
            verify_word($sformatf("random_%0d_lo_next", n), exp_lo, o_lo_next);
            expect_bit($sformatf("random_%0d_hi_pending", n), exp_phi, o_hi_pending);
            expect_bit($sformatf("random_%0d_lo_pending", n), exp_plo, o_lo_pending);
            model_hi = exp_hi;
            model_lo = exp_lo;
        end

        @(posedge clk);
        i_slots <= '0;
        @(negedge clk);
        verify_word("random_final_hi", model_hi, o_hi);
        verify_word("random_final_lo", model_lo, o_lo);
    endtask

    initial begin
        reset    = 1'b1;
        i_slots  = '0;
        seed     = 32'hd6e4_49f4;
        n_checks = 0;
        n_errors = 0;
        load_table();

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        wait_reset_release(released);

        if (!released) begin
            $display("timeout: reset was never released");
            $display("Regression failed");
            $finish;
        end else begin
            // idle after reset
            verify_word("reset_hi", `HILO_RESET_VAL, o_hi);
            verify_word("reset_lo", `HILO_RESET_VAL, o_lo);
            expect_bit("reset_hi_pending", 1'b0, o_hi_pending);
            expect_bit("reset_lo_pending", 1'b0, o_lo_pending);

            apply_table();
            check_random();

            n_errors += i_hilo_unit.i_hilo_unit_sva.fail_count;
            $display("checks %0d, errors %0d", n_checks, n_errors);
            if (n_errors == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

// File: bench/hilo_unit_sva.sv
`include "hilo_consts.svh"

module hilo_unit_sva (
    input logic            clk,
    input logic            reset,
    input hilo_pkg::word_t i_hi,
    input hilo_pkg::word_t i_lo,
    input hilo_pkg::word_t i_hi_next,
    input hilo_pkg::word_t i_lo_next,
    input logic            i_hi_pending,
    input logic            i_lo_pending
);

    // failed assertions, summed into the testbench error count
    int fail_count = 0;

    // a half nobody writes keeps its value
    a_hi_hold: assert property (@(posedge clk) disable iff (reset)
        !i_hi_pending |=> i_hi == $past(i_hi))
        else begin
            fail_count++;
            $error("HI changed in a cycle without a HI write");
        end

    a_lo_hold: assert property (@(posedge clk) disable iff (reset)
        !i_lo_pending |=> i_lo == $past(i_lo))
        else begin
            fail_count++;
            $error("LO changed in a cycle without a LO write");
        end

    // forwarded value is what lands in the register
    a_hi_load: assert property (@(posedge clk) disable iff (reset)
        i_hi_pending |=> i_hi == $past(i_hi_next))
        else begin
            fail_count++;
            $error("HI does not match the forwarded next value");
        end

    a_lo_load: assert property (@(posedge clk) disable iff (reset)
        i_lo_pending |=> i_lo == $past(i_lo_next))
        else begin
            fail_count++;
            $error("LO does not match the forwarded next value");
        end

    // both halves come out of reset at the reset value
    a_reset_val: assert property (@(posedge clk)
        reset |=> (i_hi == `HILO_RESET_VAL && i_lo == `HILO_RESET_VAL))
        else begin
            fail_count++;
            $error("HI/LO not at reset value after reset");
        end

endmodule

bind hilo_unit hilo_unit_sva i_hilo_unit_sva (
    .clk          (clk),
    .reset        (reset),
    .i_hi         (o_hi),
    .i_lo         (o_lo),
    .i_hi_next    (o_hi_next),
    .i_lo_next    (o_lo_next),
    .i_hi_pending (o_hi_pending),
    .i_lo_pending (o_lo_pending)
);

// File: src/hilo_unit.sv
module hilo_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  hilo_pkg::hilo_slot_pair_t i_slots,
    output hilo_pkg::word_t           o_hi,
    output hilo_pkg::word_t           o_lo,
    output hilo_pkg::word_t           o_hi_next,
    output hilo_pkg::word_t           o_lo_next,
    output logic                      o_hi_pending,
    output logic                      o_lo_pending
);

    // merge both retiring slots against the registered pair
    // next values and strobes double as the forwarding outputs for MFHI/MFLO
    hilo_merge i_hilo_merge (
        .i_slots    (i_slots),
        .i_hi       (o_hi),
        .i_lo       (o_lo),
        .o_hi_next  (o_hi_next),
        .o_lo_next  (o_lo_next),
        .o_hi_write (o_hi_pending),
        .o_lo_write (o_lo_pending)
    );

    // HI and LO storage, updated at the next edge
    hilo_regs i_hilo_regs (
        .clk        (clk),
        .reset      (reset),
        .i_hi_write (o_hi_pending),
        .i_lo_write (o_lo_pending),
        .i_hi_next  (o_hi_next),
        .i_lo_next  (o_lo_next),
        .o_hi       (o_hi),
        .o_lo       (o_lo)
    );

endmodule

// File: src/hilo_regs.sv
`include "hilo_consts.svh"

module hilo_regs (
    input  logic            clk,
    input  logic            reset,
    input  logic            i_hi_write,
    input  logic            i_lo_write,
    input  hilo_pkg::word_t i_hi_next,
    input  hilo_pkg::word_t i_lo_next,
    output hilo_pkg::word_t o_hi,
    output hilo_pkg::word_t o_lo
);

    // architectural HI
    always_ff @(posedge clk) begin
        if (reset) begin
            o_hi <= `HILO_RESET_VAL;
        end else if (i_hi_write) begin
            o_hi <= i_hi_next;
        end
    end

    // architectural LO, loads on its own strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            o_lo <= `HILO_RESET_VAL;
        end else if (i_lo_write) begin
            o_lo <= i_lo_next;
        end
    end

endmodule

// File: src/hilo_merge.sv
`include "hilo_consts.svh"

module hilo_merge (
    input  hilo_pkg::hilo_slot_pair_t i_slots,
    input  hilo_pkg::word_t           i_hi,
    input  hilo_pkg::word_t           i_lo,
    output hilo_pkg::word_t           o_hi_next,
    output hilo_pkg::word_t           o_lo_next,
    output logic                      o_hi_write,
    output logic                      o_lo_write
);
    import hilo_pkg::*;

    // registered pair, the only base for accumulates
    dword_t hilo_cur;

    // per-slot candidate values, before priority
    word_t  cand_hi [`HILO_SLOTS];
    word_t  cand_lo [`HILO_SLOTS];

    assign hilo_cur = {i_hi, i_lo};

    // candidate computation, one copy per slot
    for (genvar g = 0; g < `HILO_SLOTS; g++) begin : g_slot
        dword_t acc_sum;
        dword_t acc_diff;
        word_t  hi_val;
        word_t  lo_val;

        // one adder and one subtractor per slot
        // carry and borrow cross from LO into HI here
        assign acc_sum  = hilo_cur + i_slots[g].product;
        assign acc_diff = hilo_cur - i_slots[g].product;

        always_comb begin
            // plain product halves unless the op says otherwise
            hi_val = i_slots[g].product[`HILO_WORD_W +: `HILO_WORD_W];
            lo_val = i_slots[g].product[0 +: `HILO_WORD_W];
            case (i_slots[g].op)
                HILO_MOVE: begin
                    // MTHI and MTLO both carry the value in src
                    hi_val = i_slots[g].src;
                    lo_val = i_slots[g].src;
                end
                HILO_SET: begin
                    hi_val = i_slots[g].product[`HILO_WORD_W +: `HILO_WORD_W];
                    lo_val = i_slots[g].product[0 +: `HILO_WORD_W];
                end
                HILO_ADD: begin
                    hi_val = acc_sum[`HILO_WORD_W +: `HILO_WORD_W];
                    lo_val = acc_sum[0 +: `HILO_WORD_W];
                end
                HILO_SUB: begin
                    hi_val = acc_diff[`HILO_WORD_W +: `HILO_WORD_W];
                    lo_val = acc_diff[0 +: `HILO_WORD_W];
                end
                default: begin
                    hi_val = i_slots[g].product[`HILO_WORD_W +: `HILO_WORD_W];
                    lo_val = i_slots[g].product[0 +: `HILO_WORD_W];
                end
            endcase
        end

        assign cand_hi[g] = hi_val;
        assign cand_lo[g] = lo_val;
    end

    // priority merge
    // walk from the older slot down to slot 0, so the younger write lands last.
    // an accumulate in slot 0 still sees the registered pair, not slot 1's result
    always_comb begin
        o_hi_next  = i_hi;
        o_lo_next  = i_lo;
        o_hi_write = 1'b0;
        o_lo_write = 1'b0;
        for (int i = `HILO_SLOTS - 1; i >= 0; i--) begin
            if (i_slots[i].hi_write) begin
                o_hi_write = 1'b1;
                o_hi_next  = cand_hi[i];
            end
            if (i_slots[i].lo_write) begin
                o_lo_write = 1'b1;
                o_lo_next  = cand_lo[i];
            end
        end
    end

endmodule

// File: src/hilo_pkg.sv
`include "hilo_consts.svh"

package hilo_pkg;

    // one architectural word, HI or LO or a GPR source
    typedef logic [`HILO_WORD_W-1:0] word_t;

    // HI:LO pair or a full multiply/divide result, HI in the upper word
    typedef logic [2*`HILO_WORD_W-1:0] dword_t;

    // what a writing slot does to the half it targets
    typedef enum logic [1:0] {
        // MTHI / MTLO, half takes the register source
        HILO_MOVE = 2'd0,
        // MULT / DIV family, half takes its part of the product
        HILO_SET  = 2'd1,
        // MADD family, current HI:LO plus product
        HILO_ADD  = 2'd2,
        // MSUB family, current HI:LO minus product
        HILO_SUB  = 2'd3
    } hilo_op_e;

    // HI/LO part of one retiring instruction
    typedef struct packed {
        logic     hi_write;
        logic     lo_write;
        hilo_op_e op;
        word_t    src;
        dword_t   product;
    } hilo_slot_t;

    // both retiring slots, index 0 is the younger
    typedef hilo_slot_t [`HILO_SLOTS-1:0] hilo_slot_pair_t;

endpackage

// File: src/hilo_consts.svh
`ifndef HILO_CONSTS_SVH
`define HILO_CONSTS_SVH

// width of HI, of LO and of one general register
`define HILO_WORD_W 32

// retiring slots per cycle in the dual-issue pipe
// slot 0 is the younger one
`define HILO_SLOTS 2

// HI and LO after reset
`define HILO_RESET_VAL {`HILO_WORD_W{1'b0}}

`endif
